// ==== source/hash_pkg.sv ====
package hash_pkg;

	localparam int key_w = 64;
	localparam int idx_w = 10;

	// Row i is folded into the index when key bit i is set
	localparam logic [idx_w-1:0] h3_rows [0:key_w-1] = '{
		10'b0110110101, 10'b0000100000, 10'b0101101001, 10'b0001001100,
		10'b1001011101, 10'b0101000110, 10'b1100110001, 10'b1001111011,
		10'b0010110110, 10'b1101111111, 10'b1110101100, 10'b0001011101,
		10'b0111110010, 10'b1011111001, 10'b0011011101, 10'b1001001010,
		10'b1011000000, 10'b1010100010, 10'b0110101110, 10'b1100001111,
		10'b1000011011, 10'b1010100001, 10'b0001110110, 10'b1111111100,
		10'b0111110000, 10'b1010011111, 10'b0011010010, 10'b0011110110,
		10'b0011110000, 10'b0110010001, 10'b0111111101, 10'b0011000001,
		10'b0001101101, 10'b0011010010, 10'b0110001001, 10'b0100100010,
		10'b0111110100, 10'b1010011001, 10'b0010101000, 10'b0100001100,
		10'b1001111000, 10'b0011001001, 10'b1010111011, 10'b1110101000,
		10'b1101010010, 10'b1011110001, 10'b1000101000, 10'b0010111010,
		10'b1100101100, 10'b1010001000, 10'b1000000111, 10'b0001100001,
		10'b0000001110, 10'b1101010001, 10'b1001001011, 10'b0001000010,
		10'b0010111000, 10'b0000001000, 10'b1000010001, 10'b0001111000,
		10'b0101101000, 10'b0010101001, 10'b1110101100, 10'b0010000001
	};

endpackage

// ==== source/table_pkg.sv ====
package table_pkg;

	localparam int val_w = 16;

	typedef enum logic [1:0] {
		op_nop,
		op_lookup,
		op_insert,
		op_delete
	} op_e;

	typedef enum logic [1:0] {
		st_ok,
		st_miss,
		st_collision
	} status_e;

	typedef struct packed {
		logic                        valid;
		logic [hash_pkg::key_w-1:0]  key;
		logic [val_w-1:0]            value;
	} slot_t;

	typedef struct packed {
		op_e                         op;
		logic [hash_pkg::key_w-1:0]  key;
		logic [val_w-1:0]            value; // Only used by insert
	} req_t;

	typedef struct packed {
		op_e                         op;
		status_e                     status;
		logic [val_w-1:0]            value;
	} rsp_t;

endpackage

// ==== source/h3_hash.sv ====
`timescale 1ns/1ps

module h3_hash (
	input  logic [hash_pkg::key_w-1:0] key,
	output logic [hash_pkg::idx_w-1:0] idx
);

	//////////////////////////////////////////////////////////////
	// XOR of the matrix rows selected by the key bits
	//////////////////////////////////////////////////////////////

	always_comb begin
		idx = '0;
		for (int i = 0; i < hash_pkg::key_w; i++) begin
			if (key[i]) begin
				idx = idx ^ hash_pkg::h3_rows[i];
			end
		end
	end

endmodule

// ==== source/key_store.sv ====
`timescale 1ns/1ps

module key_store (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [hash_pkg::idx_w-1:0] rd_idx,
	output table_pkg::slot_t           rd_slot,
	input  logic                       wr_en,
	input  logic [hash_pkg::idx_w-1:0] wr_idx,
	input  table_pkg::slot_t           wr_slot
);

	localparam int depth  = 1 << hash_pkg::idx_w;
	localparam int word_w = hash_pkg::key_w + table_pkg::val_w;

	logic [word_w-1:0] data_mem [0:depth-1]; // Key and value per slot
	logic [depth-1:0]  valid_q;
	logic [word_w-1:0] rd_word;
	logic              rd_valid;

	//////////////////////////////////////////////////////////////
	// Key/value array, registered read
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr_en) begin
			data_mem[wr_idx] <= {wr_slot.key, wr_slot.value};
		end
		rd_word <= data_mem[rd_idx]; // Old contents on same-edge write
	end

	//////////////////////////////////////////////////////////////
	// Valid bits, emptied by reset
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q  <= '0;
			rd_valid <= 1'b0;
		end else begin
			if (wr_en) begin
				valid_q[wr_idx] <= wr_slot.valid; // Delete clears it
			end
			rd_valid <= valid_q[rd_idx];
		end
	end

	assign rd_slot = '{
		valid: rd_valid,
		key:   rd_word[word_w-1:table_pkg::val_w],
		value: rd_word[table_pkg::val_w-1:0]
	};

endmodule

// ==== source/lookup_pipe.sv ====
`timescale 1ns/1ps

module lookup_pipe (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       req_valid,
	input  table_pkg::req_t            req,
	input  logic [hash_pkg::idx_w-1:0] idx,
	output logic [hash_pkg::idx_w-1:0] rd_idx,
	input  table_pkg::slot_t           rd_slot,
	output logic                       wr_en,
	output logic [hash_pkg::idx_w-1:0] wr_idx,
	output table_pkg::slot_t           wr_slot,
	output logic                       rsp_valid,
	output table_pkg::rsp_t            rsp
);

	logic                        s1_valid;
	table_pkg::req_t             s1_req;
	logic [hash_pkg::idx_w-1:0]  s1_idx;
	logic                        s2_valid;
	table_pkg::req_t             s2_req;
	logic [hash_pkg::idx_w-1:0]  s2_idx;
	logic                        fwd_hit;
	table_pkg::slot_t            fwd_slot;
	table_pkg::slot_t            cur_slot;
	table_pkg::slot_t            new_slot;
	logic                        key_hit;
	logic                        do_write;
	table_pkg::status_e          dec_status;
	logic [table_pkg::val_w-1:0] dec_value;

	//////////////////////////////////////////////////////////////
	// Stage 1: command and index, store read address
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= req_valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_req <= req;
		s1_idx <= idx;
	end

	assign rd_idx = s1_idx; // Read completes with the move to stage 2

	//////////////////////////////////////////////////////////////
	// Stage 2: slot select, compare and decision
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			s2_valid <= 1'b0;
			fwd_hit  <= 1'b0;
		end else begin
			s2_valid <= s1_valid;
			fwd_hit  <= s1_valid && s2_valid && (s1_idx == s2_idx); // Store read is stale
		end
	end

	always_ff @(posedge clk) begin
		s2_req   <= s1_req;
		s2_idx   <= s1_idx;
		fwd_slot <= new_slot; // Slot as left by the older command
	end

	assign cur_slot = fwd_hit ? fwd_slot : rd_slot;
	assign key_hit  = cur_slot.valid && (cur_slot.key == s2_req.key);

	always_comb begin
		new_slot   = cur_slot;
		do_write   = 1'b0;
		dec_status = table_pkg::st_ok;
		dec_value  = '0;
		unique case (s2_req.op)
			table_pkg::op_lookup: begin
				if (key_hit) begin
					dec_value = cur_slot.value;
				end else begin
					dec_status = table_pkg::st_miss;
				end
			end
			table_pkg::op_insert: begin
				if (!cur_slot.valid || key_hit) begin
					do_write = 1'b1; // New key or value update
					new_slot = '{valid: 1'b1, key: s2_req.key, value: s2_req.value};
				end else begin
					dec_status = table_pkg::st_collision;
					dec_value  = cur_slot.value; // Resident value
				end
			end
			table_pkg::op_delete: begin
				if (key_hit) begin
					do_write       = 1'b1;
					new_slot.valid = 1'b0;
				end else begin
					dec_status = table_pkg::st_miss;
				end
			end
			table_pkg::op_nop: begin
			end
		endcase
	end

	assign wr_en   = s2_valid && do_write;
	assign wr_idx  = s2_idx;
	assign wr_slot = new_slot;

	//////////////////////////////////////////////////////////////
	// Response register
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= s2_valid;
		end
	end

	always_ff @(posedge clk) begin
		rsp <= '{op: s2_req.op, status: dec_status, value: dec_value};
	end

	//////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////

	// Each response traces back to a command at the input
	a_rsp_has_req: assert property (@(posedge clk) disable iff (rst)
		rsp_valid |-> $past(req_valid, 3))
		else $error("response without a command three edges earlier");

	a_write_is_update: assert property (@(posedge clk) disable iff (rst)
		wr_en |=> rsp_valid && (rsp.status == table_pkg::st_ok) &&
			(rsp.op inside {table_pkg::op_insert, table_pkg::op_delete}))
		else $error("store write not matched by an insert or delete response");

	a_collision_no_write: assert property (@(posedge clk) disable iff (rst)
		rsp_valid && (rsp.status == table_pkg::st_collision) |-> !$past(wr_en))
		else $error("collision response came with a store write");

endmodule

// ==== source/hash_table_top.sv ====
`timescale 1ns/1ps

module hash_table_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                req_valid,
	input  table_pkg::req_t     req,
	output logic                rsp_valid,
	output table_pkg::rsp_t     rsp
);

	logic [hash_pkg::idx_w-1:0] idx;
	logic [hash_pkg::idx_w-1:0] rd_idx;
	table_pkg::slot_t           rd_slot;
	logic                       wr_en;
	logic [hash_pkg::idx_w-1:0] wr_idx;
	table_pkg::slot_t           wr_slot;

	h3_hash u_hash (
		.key (req.key),
		.idx (idx)       // Registered by stage 1
	);

	lookup_pipe u_pipe (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.idx       (idx),
		.rd_idx    (rd_idx),
		.rd_slot   (rd_slot),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx),
		.wr_slot   (wr_slot),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

	key_store u_store (
		.clk     (clk),
		.rst     (rst),
		.rd_idx  (rd_idx),
		.rd_slot (rd_slot),
		.wr_en   (wr_en),
		.wr_idx  (wr_idx),
		.wr_slot (wr_slot)
	);

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	input  logic rst_req,
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	// Reset held for 4 cycles at start and on each request
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		#2 rst = 1'b0;
		forever begin
			@(posedge rst_req);
			rst = 1'b1;
			repeat (4) @(posedge clk);
			#2 rst = 1'b0;
		end
	end

endmodule

// ==== tb/hash_table_tb.sv ====
`timescale 1ns/1ps

module hash_table_tb;

	localparam int n_empty     = 8;
	localparam int n_keys      = 64;
	localparam int n_reinsert  = 4;
	localparam int cmd_total   = 2 * n_empty + 2 * n_keys + 2 * n_reinsert + 3 + 4 + 7 + n_keys;
	localparam int watchdog_ns = cmd_total * 40 + 2000;

	logic                        clk;
	logic                        rst;
	logic                        rst_req;
	logic                        req_valid;
	table_pkg::req_t             req;
	logic                        rsp_valid;
	table_pkg::rsp_t             rsp;

	integer                      seed = 32'h1557660d;
	table_pkg::slot_t            model_tbl [int]; // Expected table, by slot index
	table_pkg::rsp_t             exp_q [$];
	logic                        head_valid;
	table_pkg::op_e              head_op;
	table_pkg::status_e          head_status;
	logic [table_pkg::val_w-1:0] head_value;

	tb_clock u_clock (.rst_req(rst_req), .clk(clk), .rst(rst));

	hash_table_top UUT (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic int slot_of(logic [hash_pkg::key_w-1:0] key);
		logic [hash_pkg::idx_w-1:0] h;
		h = '0;
		for (int i = 0; i < hash_pkg::key_w; i++) begin
			if (key[i]) h = h ^ hash_pkg::h3_rows[i];
		end
		return int'(h);
	endfunction

	function automatic table_pkg::rsp_t model_step(table_pkg::op_e op,
			logic [hash_pkg::key_w-1:0] key, logic [table_pkg::val_w-1:0] value);
		int               i;
		table_pkg::slot_t s;
		table_pkg::rsp_t  r;
		logic             hit;
		i = slot_of(key);
		s = '0;
		if (model_tbl.exists(i)) s = model_tbl[i];
		hit = s.valid && (s.key == key);
		r.op = op;
		r.status = table_pkg::st_ok;
		r.value = '0;
		case (op)
			table_pkg::op_lookup: begin
				if (hit) r.value = s.value;
				else r.status = table_pkg::st_miss;
			end
			table_pkg::op_insert: begin
				if (!s.valid || hit) begin
					model_tbl[i] = '{valid: 1'b1, key: key, value: value};
				end else begin
					r.status = table_pkg::st_collision;
					r.value = s.value; // Resident value
				end
			end
			table_pkg::op_delete: begin
				if (hit) begin
					s.valid = 1'b0;
					model_tbl[i] = s;
				end else begin
					r.status = table_pkg::st_miss;
				end
			end
			default: begin
			end
		endcase
		return r;
	endfunction

	function automatic logic [hash_pkg::key_w-1:0] random_key();
		return {$random(seed), $random(seed)};
	endfunction

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task stop_with_failure;
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task refresh_head;
		head_valid = (exp_q.size() != 0);
		if (head_valid) begin
			head_op = exp_q[0].op;
			head_status = exp_q[0].status;
			head_value = exp_q[0].value;
		end
	endtask

	task send(input table_pkg::op_e op, input logic [hash_pkg::key_w-1:0] key,
			input logic [table_pkg::val_w-1:0] value);
		@(posedge clk);
		#2;
		req_valid = 1'b1;
		req = '{op: op, key: key, value: value};
		exp_q.push_back(model_step(op, key, value));
		refresh_head();
	endtask

	task drain;
		@(posedge clk);
		#2;
		req_valid = 1'b0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#2;
		end
	endtask

	// Random key whose slot is still empty in the model
	task fresh_key(output logic [hash_pkg::key_w-1:0] key);
		int n;
		n = 0;
		key = random_key();
		while (model_tbl.exists(slot_of(key)) && model_tbl[slot_of(key)].valid) begin
			n++;
			if (n > 1000) begin
				$display("Could not find a key with an empty slot");
				stop_with_failure();
			end
			key = random_key();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Response checks
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!rst && rsp_valid && exp_q.size() != 0) begin
			void'(exp_q.pop_front());
			refresh_head();
		end
	end

	a_latency: assert property (@(posedge clk) disable iff (rst)
		req_valid |-> ##3 rsp_valid)
		else begin
			$display("Response missing three cycles after its command");
			stop_with_failure();
		end

	a_expected: assert property (@(posedge clk) disable iff (rst)
		rsp_valid |-> head_valid)
		else begin
			$display("Unexpected response with no command outstanding");
			stop_with_failure();
		end

	a_op: assert property (@(posedge clk) disable iff (rst)
		rsp_valid && head_valid |-> rsp.op == head_op)
		else begin
			$display("ERROR rsp.op expected 0x%h actual 0x%h",
				$sampled(head_op), $sampled(rsp.op));
			stop_with_failure();
		end

	a_status: assert property (@(posedge clk) disable iff (rst)
		rsp_valid && head_valid |-> rsp.status == head_status)
		else begin
			$display("ERROR rsp.status expected 0x%h actual 0x%h",
				$sampled(head_status), $sampled(rsp.status));
			stop_with_failure();
		end

	a_value: assert property (@(posedge clk) disable iff (rst)
		rsp_valid && head_valid |-> rsp.value == head_value)
		else begin
			$display("ERROR rsp.value expected 0x%h actual 0x%h",
				$sampled(head_value), $sampled(rsp.value));
			stop_with_failure();
		end

	initial begin
		#(watchdog_ns);
		$display("Timeout after %0d ns, responses did not complete", watchdog_ns);
		stop_with_failure();
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin
		logic [hash_pkg::key_w-1:0]  keys [n_keys];
		logic [table_pkg::val_w-1:0] vals [n_keys];
		logic [hash_pkg::key_w-1:0]  key_a;
		logic [hash_pkg::key_w-1:0]  key_b;
		logic                        found;
		rst_req = 1'b0;
		req_valid = 1'b0;
		req = '0;
		refresh_head();
		wait (rst === 1'b1);
		wait (rst === 1'b0);

		for (int i = 0; i < n_empty; i++) begin // Empty table
			key_a = random_key();
			send(table_pkg::op_lookup, key_a, '0);
			send(table_pkg::op_delete, key_a, '0);
		end
		drain();

		for (int i = 0; i < n_keys; i++) begin
			keys[i] = random_key();
			vals[i] = $random(seed);
			send(table_pkg::op_insert, keys[i], vals[i]);
		end
		for (int i = 0; i < n_keys; i++) send(table_pkg::op_lookup, keys[i], '0);
		for (int i = 0; i < n_reinsert; i++) begin // Value update
			send(table_pkg::op_insert, keys[i], vals[i] ^ 16'h5a5a);
			send(table_pkg::op_lookup, keys[i], '0);
		end
		drain();

		fresh_key(key_a);
		found = 1'b0;
		for (int n = 0; n < 100000 && !found; n++) begin
			key_b = random_key();
			found = (key_b != key_a) && (slot_of(key_b) == slot_of(key_a));
		end
		if (!found) begin
			$display("No pair of keys sharing an index was found");
			stop_with_failure();
		end
		send(table_pkg::op_insert, key_a, 16'h1234);
		send(table_pkg::op_insert, key_b, 16'h4321); // Collides
		send(table_pkg::op_lookup, key_a, '0);
		drain();

		fresh_key(key_a);
		send(table_pkg::op_insert, key_a, 16'hbeef);
		drain();
		send(table_pkg::op_delete, key_a, '0);
		drain();
		send(table_pkg::op_lookup, key_a, '0);
		drain();
		send(table_pkg::op_delete, key_a, '0);
		drain();

		fresh_key(key_a); // Back to back, forwarded
		send(table_pkg::op_insert, key_a, 16'h0f0f);
		send(table_pkg::op_lookup, key_a, '0);
		send(table_pkg::op_delete, key_a, '0);
		send(table_pkg::op_lookup, key_a, '0);
		fresh_key(key_b);
		send(table_pkg::op_insert, key_b, 16'h1111);
		send(table_pkg::op_insert, key_b, 16'h2222);
		send(table_pkg::op_lookup, key_b, '0);
		drain();

		@(posedge clk);
		#2 rst_req = 1'b1; // Mid-run reset
		wait (rst === 1'b1);
		model_tbl.delete();
		@(posedge clk);
		#2 rst_req = 1'b0;
		wait (rst === 1'b0);
		for (int i = 0; i < n_keys; i++) send(table_pkg::op_lookup, keys[i], '0);
		drain();

		repeat (4) @(posedge clk);
		if (exp_q.size() == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("Responses still outstanding at the end of the run");
			stop_with_failure();
		end
	end

endmodule

// ==== src.f ====
source/hash_pkg.sv
source/table_pkg.sv
source/h3_hash.sv
source/key_store.sv
source/lookup_pipe.sv
source/hash_table_top.sv
tb/tb_clock.sv
tb/hash_table_tb.sv
